// ==== verif/mmio_stim.txt ====
# W addr bytes data | R addr expected | K scancode | S switches
# C cycles between two rtc reads | D seg value checked over one frame
W 80000000 8 0123456789abcdef
R 80000000 0123456789abcdef
W 80000008 8 0000000000000000
W 8000000b 1 00000000000000a5
R 80000008 00000000a5000000
W 8000000e 2 000000000000beef
R 80000008 beef0000a5000000
W 80000004 4 00000000cafef00d
R 80000000 cafef00d89abcdef
W 80000001 1 ffffffffffffff5a
R 80000000 cafef00d89ab5aef
W 800001f8 8 fedcba9876543210
R 800001f8 fedcba9876543210
W 80000200 8 1111111111111111
R 80000200 0000000000000000
R 80000000 cafef00d89ab5aef
W 7ffffff8 8 2222222222222222
R 7ffffff8 0000000000000000
R 800001f8 fedcba9876543210
R a0000050 0000000000000000
K 1c
K 32
K 21
K 23
R a0000060 000000000000001c
R a0000060 0000000000000032
R a0000060 0000000000000021
R a0000060 0000000000000023
R a0000060 0000000000000000
K 5a
R a0000062 000000000000005a
S a7
R a0000070 00000000000000a7
C 13
W a0000090 8 123456789abc5e3d
R a0000090 0000000000000000
W a0000080 8 ffffffff89abcdef
D 89abcdef
W a0000084 4 0000000001234567
D 01234567

// ==== build.f ====
hdl/mmio_map_pkg.sv
hdl/mmio_access_pkg.sv
hdl/kbd_fifo.sv
hdl/data_ram.sv
hdl/mmio.sv
hdl/seg_scan.sv
hdl/mmio_top.sv
verif/tb_clk_gen.sv
verif/mmio_tb.sv

// ==== Bender.yml ====
package:
  name: mmio

sources:
  - hdl/mmio_map_pkg.sv
  - hdl/mmio_access_pkg.sv
  - hdl/kbd_fifo.sv
  - hdl/data_ram.sv
  - hdl/mmio.sv
  - hdl/seg_scan.sv
  - hdl/mmio_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/mmio_tb.sv

// ==== verif/mmio_tb.sv ====
`timescale 1ns/10ps

module mmio_tb;

    import mmio_map_pkg::*;
    import mmio_access_pkg::*;

    // hex digit patterns with segment a in bit 0, digit f in the top slot
    localparam logic [16*7-1:0] hex_segs = {
        7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f, 7'h7f,
        7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
    };

    logic                    clk;
    logic                    rst;
    logic                    kb_valid;
    logic [kb_width-1:0]     kb_code;
    logic [swt_width-1:0]    swt_rdata;
    logic [addr_width-1:0]   mem_raddr;
    logic [addr_width-1:0]   mem_waddr;
    logic [xlen-1:0]         mem_wdata;
    logic                    mem_wen;
    logic                    mem_ren;
    access_e                 wdt_op;
    logic                    kb_credit;
    logic [xlen-1:0]         mem_rdata;
    logic [led_width-1:0]    led_wdata;
    logic [seg_digits-1:0]   seg_an;
    logic [seg_segments-1:0] seg_cathode;

    // reference state
    logic [7:0]              ram_model [ram_words*xlen_bytes];
    logic [kb_width-1:0]     kbd_model [$];
    logic [led_width-1:0]    led_model;
    int                      credits;
    logic                    pop_next_edge;
    logic                    credit_expect;
    logic                    monitor_on;
    int                      watchdog_cycles;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    mmio_top uut (
        .clk         (clk),
        .rst         (rst),
        .kb_valid    (kb_valid),
        .kb_code     (kb_code),
        .swt_rdata   (swt_rdata),
        .mem_raddr   (mem_raddr),
        .mem_waddr   (mem_waddr),
        .mem_wdata   (mem_wdata),
        .mem_wen     (mem_wen),
        .mem_ren     (mem_ren),
        .wdt_op      (wdt_op),
        .kb_credit   (kb_credit),
        .mem_rdata   (mem_rdata),
        .led_wdata   (led_wdata),
        .seg_an      (seg_an),
        .seg_cathode (seg_cathode)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(
        input logic [xlen-1:0] got,
        input logic [xlen-1:0] exp,
        input string           what
    );
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic expect_fields(input int got, input int want, input logic [7:0] cmd);
        if (got != want) begin
            abort_run($sformatf("stimulus line for command %c is missing fields", cmd));
        end
    endtask

    // lands 1 ns after the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [xlen-1:0] ram_dword(input logic [addr_width-1:0] addr);
        logic [xlen-1:0] dw;
        int              base;
        base = int'(addr - ram_base) & ~7;
        for (int i = 0; i < xlen_bytes; i++) begin
            dw[8*i +: 8] = ram_model[base + i];
        end
        return dw;
    endfunction

    task automatic bus_read(
        input  logic [addr_width-1:0] addr,
        input  logic                  expect_pop,
        output logic [xlen-1:0]       data
    );
        mem_ren       = 1'b1;
        mem_raddr     = addr;
        pop_next_edge = expect_pop;
        // sampled just before the edge
        #8;
        data = mem_rdata;
        next_cycle();
        mem_ren       = 1'b0;
        pop_next_edge = 1'b0;
    endtask

    task automatic bus_write(
        input logic [addr_width-1:0] addr,
        input int                    nbytes,
        input logic [xlen-1:0]       data
    );
        int lane;
        mem_wen   = 1'b1;
        mem_waddr = addr;
        mem_wdata = data;
        case (nbytes)
            1:       wdt_op = acc_byte;
            2:       wdt_op = acc_half;
            4:       wdt_op = acc_word;
            8:       wdt_op = acc_dword;
            default: abort_run($sformatf("write width of %0d bytes is not supported", nbytes));
        endcase
        #8;
        check_value(led_wdata, led_model, "led register before the write edge");
        next_cycle();
        mem_wen = 1'b0;
        // lanes from the byte offset up to lane 7
        if ((addr >= ram_base) && (addr < ram_base + ram_len)) begin
            lane = int'(addr[2:0]);
            for (int i = 0; i < nbytes && lane + i < xlen_bytes; i++) begin
                ram_model[int'(addr - ram_base) + i] = data[8*i +: 8];
            end
        end
        if ((addr >= led_addr) && (addr < led_addr + peri_len)) begin
            led_model = data[led_width-1:0];
        end
        #8;
        check_value(led_wdata, led_model, "led register in the cycle after the write");
        next_cycle();
    endtask

    task automatic kbd_push(input logic [kb_width-1:0] code);
        int waited;
        waited = 0;
        // no credit means the source holds off
        while (credits == 0) begin
            if (waited == 50) begin
                abort_run("keyboard source has no credit left and none came back");
            end else begin
                next_cycle();
                waited++;
            end
        end
        credits--;
        kb_valid = 1'b1;
        kb_code  = code;
        kbd_model.push_back(code);
        next_cycle();
        kb_valid = 1'b0;
    endtask

    task automatic check_frame(input logic [seg_width-1:0] value);
        logic [seg_digits-1:0] prev_an;
        int                    waited;
        waited  = 0;
        prev_an = '1;
        #8;
        // frame starts where blank turns into digit 0
        while (!((prev_an == '0) && (seg_an == 8'h01))) begin
            if (waited == 100) begin
                abort_run("display scanner never moved from blank to digit 0");
            end else begin
                prev_an = seg_an;
                waited++;
                #10;
            end
        end
        for (int d = 0; d < seg_digits; d++) begin
            for (int c = 0; c <= seg_scan_cycles; c++) begin
                if (c < seg_scan_cycles) begin
                    check_value(seg_an, 1 << d, $sformatf("anode of digit %0d", d));
                    check_value(seg_cathode, hex_segs[7*value[4*d +: 4] +: 7],
                                $sformatf("segments of digit %0d", d));
                end else begin
                    check_value(seg_an, '0, $sformatf("blank after digit %0d", d));
                end
                #10;
            end
        end
        next_cycle();
    endtask

    // credit pulse must follow each pop by exactly one edge
    always @(posedge clk) begin
        credit_expect <= pop_next_edge;
    end

    always @(negedge clk) begin
        if (monitor_on) begin
            check_value(kb_credit, credit_expect, "keyboard credit pulse");
            if (kb_credit) begin
                credits++;
                if (credits > kbd_depth) begin
                    abort_run("keyboard credit count went above the queue depth");
                end
            end
        end
    end

    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("timeout, run still going after %0d cycles", watchdog_cycles));
    end

    initial begin
        int                    fd;
        int                    rc;
        int                    cmds;
        int                    nbytes;
        logic [7:0]            cmd;
        logic [8*128-1:0]      line_buf;
        logic [addr_width-1:0] addr;
        logic [xlen-1:0]       data;
        logic [xlen-1:0]       exp_val;
        logic [xlen-1:0]       model_val;
        logic [xlen-1:0]       t_first;
        logic                  kbd_hit;
        logic                  ram_hit;
        logic                  pop;
        kb_valid      = 1'b0;
        kb_code       = '0;
        swt_rdata     = '0;
        mem_raddr     = '0;
        mem_waddr     = '0;
        mem_wdata     = '0;
        mem_wen       = 1'b0;
        mem_ren       = 1'b0;
        wdt_op        = acc_dword;
        pop_next_edge = 1'b0;
        credit_expect = 1'b0;
        monitor_on    = 1'b0;
        led_model     = '0;
        credits       = kbd_depth;
        void'($urandom(94));

        // first pass only counts commands for the watchdog
        fd = $fopen("verif/mmio_stim.txt", "r");
        if (fd == 0) begin
            abort_run("could not open verif/mmio_stim.txt");
        end
        cmds = 0;
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd != "#") begin
                cmds++;
            end
            rc = $fgets(line_buf, fd);
        end
        $fclose(fd);
        watchdog_cycles = cmds * 100 + 1000;

        @(negedge rst);
        monitor_on = 1'b1;
        bus_read(rtc_addr, 1'b0, data);
        check_value(data, '0, "cycle counter in the first cycle after reset");
        check_value(led_wdata, '0, "led register after reset");

        fd = $fopen("verif/mmio_stim.txt", "r");
        while ($fscanf(fd, " %c", cmd) == 1) begin
            if (cmd == "#") begin
                rc = $fgets(line_buf, fd);
            end else begin
                repeat ($urandom_range(3)) next_cycle();
                case (cmd)
                    "W": begin
                        rc = $fscanf(fd, " %h %d %h", addr, nbytes, data);
                        expect_fields(rc, 3, cmd);
                        bus_write(addr, nbytes, data);
                    end
                    "R": begin
                        rc = $fscanf(fd, " %h %h", addr, exp_val);
                        expect_fields(rc, 2, cmd);
                        kbd_hit   = (addr >= kbd_addr) && (addr < kbd_addr + kbd_len);
                        ram_hit   = (addr >= ram_base) && (addr < ram_base + ram_len);
                        pop       = kbd_hit && (kbd_model.size() != 0);
                        model_val = '0;
                        if (pop) begin
                            model_val[kb_width-1:0] = kbd_model.pop_front();
                        end else if (ram_hit) begin
                            model_val = ram_dword(addr);
                        end
                        bus_read(addr, pop, data);
                        check_value(data, exp_val, $sformatf("read of %h", addr));
                        if (kbd_hit || ram_hit) begin
                            check_value(data, model_val, $sformatf("read of %h vs model", addr));
                        end
                    end
                    "K": begin
                        rc = $fscanf(fd, " %h", data);
                        expect_fields(rc, 1, cmd);
                        kbd_push(data[kb_width-1:0]);
                    end
                    "S": begin
                        rc = $fscanf(fd, " %h", data);
                        expect_fields(rc, 1, cmd);
                        swt_rdata = data[swt_width-1:0];
                    end
                    "C": begin
                        rc = $fscanf(fd, " %d", nbytes);
                        expect_fields(rc, 1, cmd);
                        bus_read(rtc_addr, 1'b0, t_first);
                        repeat (nbytes - 1) next_cycle();
                        bus_read(rtc_addr, 1'b0, data);
                        check_value(data - t_first, nbytes, "cycles between two rtc reads");
                    end
                    "D": begin
                        rc = $fscanf(fd, " %h", data);
                        expect_fields(rc, 1, cmd);
                        check_frame(data[seg_width-1:0]);
                    end
                    default: abort_run($sformatf("unknown command %c in stimulus file", cmd));
                endcase
            end
        end
        $fclose(fd);

        // let the last credits come home
        repeat (3) next_cycle();
        check_value(credits, kbd_depth, "keyboard credits after the queue drained");

        $display("Finished with no errors");
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/10ps

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // held over 16 rising edges, released just after the last one
    initial begin
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== hdl/mmio_top.sv ====
`timescale 1ns/10ps

module mmio_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  kb_valid,
    input  logic [mmio_map_pkg::kb_width-1:0]     kb_code,
    input  logic [mmio_map_pkg::swt_width-1:0]    swt_rdata,
    input  logic [mmio_map_pkg::addr_width-1:0]   mem_raddr,
    input  logic [mmio_map_pkg::addr_width-1:0]   mem_waddr,
    input  logic [mmio_map_pkg::xlen-1:0]         mem_wdata,
    input  logic                                  mem_wen,
    input  logic                                  mem_ren,
    input  mmio_access_pkg::access_e              wdt_op,
    output logic                                  kb_credit,
    output logic [mmio_map_pkg::xlen-1:0]         mem_rdata,
    output logic [mmio_map_pkg::led_width-1:0]    led_wdata,
    output logic [mmio_map_pkg::seg_digits-1:0]   seg_an,
    output logic [mmio_map_pkg::seg_segments-1:0] seg_cathode
);

    import mmio_map_pkg::*;

    logic [kb_width-1:0]  kb_rdata;
    logic                 kb_ready;
    logic                 sig_rd_kb;
    logic [seg_width-1:0] seg_wdata;

    // input side
    kbd_fifo u_kbd_fifo (
        .clk       (clk),
        .rst       (rst),
        .kb_valid  (kb_valid),
        .kb_code   (kb_code),
        .sig_rd_kb (sig_rd_kb),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .kb_credit (kb_credit)
    );

    mmio u_mmio (
        .clk       (clk),
        .rst       (rst),
        .mem_raddr (mem_raddr),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .mem_wen   (mem_wen),
        .mem_ren   (mem_ren),
        .wdt_op    (wdt_op),
        .kb_rdata  (kb_rdata),
        .kb_ready  (kb_ready),
        .swt_rdata (swt_rdata),
        .mem_rdata (mem_rdata),
        .sig_rd_kb (sig_rd_kb),
        .seg_wdata (seg_wdata),
        .led_wdata (led_wdata)
    );

    // output side
    seg_scan u_seg_scan (
        .clk         (clk),
        .rst         (rst),
        .seg_wdata   (seg_wdata),
        .seg_an      (seg_an),
        .seg_cathode (seg_cathode)
    );

endmodule

// ==== hdl/seg_scan.sv ====
`timescale 1ns/10ps

module seg_scan (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [mmio_map_pkg::seg_width-1:0]    seg_wdata,
    output logic [mmio_map_pkg::seg_digits-1:0]   seg_an,
    output logic [mmio_map_pkg::seg_segments-1:0] seg_cathode
);

    import mmio_map_pkg::*;
    import mmio_access_pkg::*;

    scan_state_e                state;
    logic [seg_dwell_width-1:0] dwell;
    logic [seg_digit_width-1:0] digit;
    logic [3:0]                 nibble;
    logic [seg_segments-1:0]    pattern;

    // blank first, then digit 0 after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= scan_blank;
            dwell <= '0;
            digit <= '0;
        end else begin
            unique case (state)
                scan_blank: begin
                    state <= scan_drive;
                    dwell <= '0;
                end
                scan_drive: begin
                    if (dwell == seg_dwell_last) begin
                        // digit index wraps after the last one
                        state <= scan_blank;
                        digit <= digit + 1'b1;
                    end else begin
                        dwell <= dwell + 1'b1;
                    end
                end
                default: state <= scan_blank;
            endcase
        end
    end

    assign nibble = seg_wdata[4*digit +: 4];

    // segment a in bit 0, lit when high
    always_comb begin
        unique case (nibble)
            4'h0: pattern = 7'h3f;
            4'h1: pattern = 7'h06;
            4'h2: pattern = 7'h5b;
            4'h3: pattern = 7'h4f;
            4'h4: pattern = 7'h66;
            4'h5: pattern = 7'h6d;
            4'h6: pattern = 7'h7d;
            4'h7: pattern = 7'h07;
            4'h8: pattern = 7'h7f;
            4'h9: pattern = 7'h6f;
            4'ha: pattern = 7'h77;
            4'hb: pattern = 7'h7c;
            4'hc: pattern = 7'h39;
            4'hd: pattern = 7'h5e;
            4'he: pattern = 7'h79;
            default: pattern = 7'h71;
        endcase
    end

    always_comb begin
        seg_an      = '0;
        seg_cathode = '0;
        if (state == scan_drive) begin
            seg_an[digit] = 1'b1;
            seg_cathode   = pattern;
        end
    end

endmodule

// ==== hdl/mmio.sv ====
`timescale 1ns/10ps

module mmio (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [mmio_map_pkg::addr_width-1:0] mem_raddr,
    input  logic [mmio_map_pkg::addr_width-1:0] mem_waddr,
    input  logic [mmio_map_pkg::xlen-1:0]       mem_wdata,
    input  logic                                mem_wen,
    input  logic                                mem_ren,
    input  mmio_access_pkg::access_e            wdt_op,
    input  logic [mmio_map_pkg::kb_width-1:0]   kb_rdata,
    input  logic                                kb_ready,
    input  logic [mmio_map_pkg::swt_width-1:0]  swt_rdata,
    output logic [mmio_map_pkg::xlen-1:0]       mem_rdata,
    output logic                                sig_rd_kb,
    output logic [mmio_map_pkg::seg_width-1:0]  seg_wdata,
    output logic [mmio_map_pkg::led_width-1:0]  led_wdata
);

    import mmio_map_pkg::*;

    logic [xlen-1:0] ram_rdata;
    logic [xlen-1:0] rtc_count;
    logic            rd_ram;
    logic            rd_kbd;
    logic            rd_swt;
    logic            rd_rtc;
    logic            wr_ram;
    logic            wr_seg;
    logic            wr_led;

    // read side decode
    assign rd_ram = in_range(mem_raddr, ram_base, ram_len);
    assign rd_kbd = in_range(mem_raddr, kbd_addr, kbd_len);
    assign rd_swt = in_range(mem_raddr, swt_addr, peri_len);
    assign rd_rtc = in_range(mem_raddr, rtc_addr, rtc_len);

    // write side decode, anything else is dropped
    assign wr_ram = mem_wen && in_range(mem_waddr, ram_base, ram_len);
    assign wr_seg = mem_wen && in_range(mem_waddr, seg_addr, peri_len);
    assign wr_led = mem_wen && in_range(mem_waddr, led_addr, peri_len);

    data_ram u_data_ram (
        .clk    (clk),
        .raddr  (mem_raddr),
        .waddr  (mem_waddr),
        .wdata  (mem_wdata),
        .wen    (wr_ram),
        .wdt_op (wdt_op),
        .rdata  (ram_rdata)
    );

    // read mux, zero when nothing is hit
    always_comb begin
        mem_rdata = '0;
        sig_rd_kb = 1'b0;
        if (mem_ren) begin
            if (rd_ram) begin
                mem_rdata = ram_rdata;
            end else if (rd_kbd) begin
                // empty queue reads as zero and pops nothing
                if (kb_ready) begin
                    sig_rd_kb = 1'b1;
                    mem_rdata = {{(xlen - kb_width){1'b0}}, kb_rdata};
                end
            end else if (rd_swt) begin
                mem_rdata = {{(xlen - swt_width){1'b0}}, swt_rdata};
            end else if (rd_rtc) begin
                mem_rdata = rtc_count;
            end
        end
    end

    // real-time clock is just a cycle count
    always_ff @(posedge clk) begin
        if (rst) begin
            rtc_count <= '0;
        end else begin
            rtc_count <= rtc_count + 1'b1;
        end
    end

    // display and led output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            seg_wdata <= '0;
            led_wdata <= '0;
        end else begin
            if (wr_seg) begin
                seg_wdata <= mem_wdata[seg_width-1:0];
            end
            if (wr_led) begin
                led_wdata <= mem_wdata[led_width-1:0];
            end
        end
    end

endmodule

// ==== hdl/data_ram.sv ====
`timescale 1ns/10ps

module data_ram (
    input  logic                                clk,
    input  logic [mmio_map_pkg::addr_width-1:0] raddr,
    input  logic [mmio_map_pkg::addr_width-1:0] waddr,
    input  logic [mmio_map_pkg::xlen-1:0]       wdata,
    input  logic                                wen,
    input  mmio_access_pkg::access_e            wdt_op,
    output logic [mmio_map_pkg::xlen-1:0]       rdata
);

    import mmio_map_pkg::*;
    import mmio_access_pkg::*;

    logic [xlen-1:0]           mem [ram_words];
    logic [ram_idx_width-1:0]  rd_idx;
    logic [ram_idx_width-1:0]  wr_idx;
    logic [byte_off_width-1:0] wr_off;
    logic [xlen_bytes-1:0]     lane_base;
    logic [xlen_bytes-1:0]     lane_mask;
    logic [xlen-1:0]           lane_data;

    // doubleword index sits just above the byte offset
    assign rd_idx = raddr[byte_off_width +: ram_idx_width];
    assign wr_idx = waddr[byte_off_width +: ram_idx_width];
    assign wr_off = waddr[byte_off_width-1:0];

    // aligned doubleword, no read latency
    assign rdata = mem[rd_idx];

    always_comb begin
        unique case (wdt_op)
            acc_byte:  lane_base = 8'h01;
            acc_half:  lane_base = 8'h03;
            acc_word:  lane_base = 8'h0f;
            default:   lane_base = 8'hff;
        endcase
    end

    // low bytes of wdata move up to the addressed lanes
    assign lane_mask = lane_base << wr_off;
    assign lane_data = wdata << {wr_off, 3'b000};

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < xlen_bytes; i++) begin
                if (lane_mask[i]) begin
                    mem[wr_idx][8*i +: 8] <= lane_data[8*i +: 8];
                end
            end
        end
    end

endmodule

// ==== hdl/kbd_fifo.sv ====
`timescale 1ns/10ps

module kbd_fifo (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              kb_valid,
    input  logic [mmio_map_pkg::kb_width-1:0] kb_code,
    input  logic                              sig_rd_kb,
    output logic [mmio_map_pkg::kb_width-1:0] kb_rdata,
    output logic                              kb_ready,
    output logic                              kb_credit
);

    import mmio_map_pkg::*;

    logic [kb_width-1:0]    queue [kbd_depth];
    logic [kbd_ptr_width-1:0] wr_ptr;
    logic [kbd_ptr_width-1:0] rd_ptr;
    logic [kbd_ptr_width:0]   count;
    logic                     push;
    logic                     pop;

    // source only pushes with a credit in hand, so there is always room
    assign push = kb_valid;
    assign pop  = sig_rd_kb && kb_ready;

    // head of queue straight to the decoder
    assign kb_ready = (count != '0);
    assign kb_rdata = queue[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= kb_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            kb_credit <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            unique case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // one credit back per entry freed
            kb_credit <= pop;
        end
    end

endmodule

// ==== hdl/mmio_access_pkg.sv ====
package mmio_access_pkg;

    // store width selected by the core for each write
    typedef enum logic [1:0] {
        acc_byte  = 2'd0,
        acc_half  = 2'd1,
        acc_word  = 2'd2,
        acc_dword = 2'd3
    } access_e;

    // display scanner phases
    // blank sits between digits so the old pattern never shows on the next anode
    typedef enum logic {
        scan_blank = 1'b0,
        scan_drive = 1'b1
    } scan_state_e;

endpackage

// ==== hdl/mmio_map_pkg.sv ====
package mmio_map_pkg;

    // core data and bus widths
    localparam int xlen           = 64;
    localparam int addr_width     = 32;
    localparam int xlen_bytes     = xlen / 8;
    localparam int byte_off_width = $clog2(xlen_bytes);

    // data ram, 512 bytes as 64 doublewords
    localparam logic [addr_width-1:0] ram_base = 32'h8000_0000;
    localparam logic [addr_width-1:0] ram_len  = 32'h0000_0200;
    localparam int ram_words     = 64;
    localparam int ram_idx_width = $clog2(ram_words);

    // peripheral windows
    localparam logic [addr_width-1:0] kbd_addr = 32'ha000_0060;
    localparam logic [addr_width-1:0] kbd_len  = 32'h0000_0004;
    localparam logic [addr_width-1:0] swt_addr = 32'ha000_0070;
    localparam logic [addr_width-1:0] rtc_addr = 32'ha000_0048;
    localparam logic [addr_width-1:0] rtc_len  = 32'h0000_0008;
    localparam logic [addr_width-1:0] seg_addr = 32'ha000_0080;
    localparam logic [addr_width-1:0] led_addr = 32'ha000_0090;
    localparam logic [addr_width-1:0] peri_len = 32'h0000_0008;

    // peripheral port widths
    localparam int kb_width  = 8;
    localparam int swt_width = 8;
    localparam int seg_width = 32;
    localparam int led_width = 16;

    // keyboard queue, depth doubles as the starting credit count
    localparam int kbd_depth     = 4;
    localparam int kbd_ptr_width = $clog2(kbd_depth);

    // display scanner, dwell kept short for simulation
    localparam int seg_scan_cycles = 4;
    localparam int seg_digits      = seg_width / 4;
    localparam int seg_digit_width = $clog2(seg_digits);
    localparam int seg_dwell_width = $clog2(seg_scan_cycles);
    localparam int seg_segments    = 7;
    localparam logic [seg_dwell_width-1:0] seg_dwell_last = seg_dwell_width'(seg_scan_cycles - 1);

    // true when addr falls in [base, base + len)
    function automatic logic in_range(
        input logic [addr_width-1:0] addr,
        input logic [addr_width-1:0] base,
        input logic [addr_width-1:0] len
    );
        return (addr >= base) && ((addr - base) < len);
    endfunction

endpackage
